// ==== vlog.f ====
source/mips_ctrl_pkg.sv
source/instr_if.sv
source/instr_capture.sv
source/main_decoder.sv
source/alu_decoder.sv
source/ctrl_issue.sv
source/control_unit.sv
bench/control_unit_checker.sv
bench/control_unit_tb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - source/mips_ctrl_pkg.sv
  - source/instr_if.sv
  - source/instr_capture.sv
  - source/main_decoder.sv
  - source/alu_decoder.sv
  - source/ctrl_issue.sv
  - source/control_unit.sv
  - target: test
    files:
      - bench/control_unit_checker.sv
      - bench/control_unit_tb.sv

// ==== bench/control_unit_stim.txt ====
// instr ctrl_word mem_read alu_op dest_reg illegal, all hex
// ctrl_word is the issued 16 bit control word after illegal squashing
00221820 dc00 1 0 03 0  // add
00853022 dc00 1 1 06 0  // sub
00e84824 dc00 1 2 09 0  // and
0043f827 dc00 1 5 1f 0  // nor
0022202b dc00 1 7 04 0  // sltu
00053883 dc00 1 a 07 0  // sra
00000000 0000 1 0 00 0  // noop
00004010 c00c 1 0 08 0  // mfhi
00004812 c008 1 0 09 0  // mflo
00640018 000b 1 0 04 0  // mult
00640019 c00a 1 0 00 0  // multu
20220010 a010 1 0 02 0  // addi
28050004 b410 1 6 05 0  // slti
2c060004 a410 1 7 06 0  // sltiu
300700ff a800 1 2 07 0  // andi
340800ff ac00 1 3 08 0  // ori
380900ff b000 1 4 09 0  // xori
3c0a1234 8004 1 0 0a 0  // lui
8fab0008 a110 1 0 0b 0  // lw
afac0008 2210 0 0 0c 0  // sw
08000040 1820 1 1 00 0  // j
10220003 1880 1 1 02 0  // beq
1464fffe 1840 1 1 04 0  // bne
fc221820 0000 0 0 02 1  // unknown opcode
00221801 5c00 0 f 03 1  // unknown funct

// ==== bench/control_unit_tb.sv ====
// Testbench for the control unit decode stage
// Replays the stim file with random idle gaps and checks each issued decode in order
module control_unit_tb
    import mips_ctrl_pkg::*;
();

    localparam int NUM_CASES      = 25;
    localparam int FIELDS         = 6;  // Words per stim line
    localparam int TIMEOUT_CYCLES = 3 + 6 * NUM_CASES + 20;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        ctrl_valid;
    logic        reg_write;
    logic        reg_dst;
    logic        alu_src_a;
    logic        mem_write;
    logic        mem_read;
    logic        mem_to_reg;
    logic        beq;
    logic        bne;
    logic        jump;
    logic        se_ze;
    logic        start_mult;
    logic        mult_sign;
    out_sel_t    out_select;
    alu_op_t     alu_op;
    logic [4:0]  dest_reg;
    logic        illegal;

    logic [31:0] stim_mem [0:NUM_CASES*FIELDS-1];
    int          expect_q[$];        // Case index per outstanding strobe
    int          strobe_cycle_q[$];  // Cycle each strobe was seen
    int          cycle_count;
    int          seed_init;
    int          gap;

    control_unit dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %0b got %0b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_out_sel(string name, out_sel_t expected, out_sel_t actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %s got %s", $time, name,
                     expected.name(), actual.name());
            abort_run();
        end
    endtask

    task automatic check_alu_op(string name, alu_op_t expected, alu_op_t actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %s got %s", $time, name,
                     expected.name(), actual.name());
            abort_run();
        end
    endtask

    task automatic check_reg(string name, logic [4:0] expected, logic [4:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t: %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_result();
        int         idx;
        int         sent;
        ctrl_word_t exp_ctrl;
        if (expect_q.size() == 0) begin
            $display("ctrl_valid went high at time %0t with no instruction outstanding", $time);
            abort_run();
        end else begin
            idx      = expect_q.pop_front();
            sent     = strobe_cycle_q.pop_front();
            exp_ctrl = ctrl_word_t'(stim_mem[idx*FIELDS+1][15:0]);
            if (cycle_count - sent != 2) begin
                $display("FAIL time %0t: latency expected 2 got %0d", $time, cycle_count - sent);
                abort_run();
            end
            check_bit("reg_write", exp_ctrl.reg_write, reg_write);
            check_bit("reg_dst", exp_ctrl.reg_dst, reg_dst);
            check_bit("alu_src_a", exp_ctrl.alu_src_a, alu_src_a);
            check_bit("mem_write", exp_ctrl.mem_write, mem_write);
            check_bit("mem_to_reg", exp_ctrl.mem_to_reg, mem_to_reg);
            check_bit("beq", exp_ctrl.beq, beq);
            check_bit("bne", exp_ctrl.bne, bne);
            check_bit("jump", exp_ctrl.jump, jump);
            check_bit("se_ze", exp_ctrl.se_ze, se_ze);
            check_bit("start_mult", exp_ctrl.start_mult, start_mult);
            check_bit("mult_sign", exp_ctrl.mult_sign, mult_sign);
            check_out_sel("out_select", exp_ctrl.out_select, out_select);
            check_bit("mem_read", stim_mem[idx*FIELDS+2][0], mem_read);
            check_alu_op("alu_op", alu_op_t'(stim_mem[idx*FIELDS+3][3:0]), alu_op);
            check_reg("dest_reg", stim_mem[idx*FIELDS+4][4:0], dest_reg);
            check_bit("illegal", stim_mem[idx*FIELDS+5][0], illegal);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (dut.u_checker.fail_count != 0) begin
            $display("A checker assertion failed before time %0t", $time);
            abort_run();
        end
        if (instr_valid) strobe_cycle_q.push_back(cycle_count);
        if (ctrl_valid) compare_result();
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        seed_init   = $urandom(50);
        clk         = 1'b0;
        arst_n     <= 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        cycle_count = 0;
        $readmemh("bench/control_unit_stim.txt", stim_mem);

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < NUM_CASES; i++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= stim_mem[i*FIELDS];
            expect_q.push_back(i);
            gap = $urandom_range(3, 0);  // Zero gives back-to-back strobes
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        // Fixed two cycle latency, so a short drain is enough
        repeat (4) @(negedge clk);
        if (expect_q.size() != 0) begin
            $display("%0d expected results never came out", expect_q.size());
            $display("Something failed");
            $fatal(1, "Results missing at the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== bench/control_unit_checker.sv ====
// Output consistency assertions for the control unit decode stage
module control_unit_checker (
    input logic clk,
    input logic arst_n,
    input logic ctrl_valid,
    input logic reg_write,
    input logic mem_write,
    input logic mem_read,
    input logic start_mult,
    input logic beq,
    input logic bne,
    input logic illegal
);

    int fail_count = 0;  // Failed assertions so far

    // Issue register is held clear
    assert property (@(posedge clk) !arst_n |-> !ctrl_valid)
        else begin
            fail_count++;
            $error("ctrl_valid high during reset");
        end

    // Illegal instructions have no side effects
    assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> (!reg_write && !mem_write && !start_mult))
        else begin
            fail_count++;
            $error("illegal issued with a write or multiply start");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        (ctrl_valid && !illegal) |-> (mem_read == !mem_write))
        else begin
            fail_count++;
            $error("mem_read does not mirror mem_write");
        end

    assert property (@(posedge clk) disable iff (!arst_n) !(beq && bne))
        else begin
            fail_count++;
            $error("beq and bne high together");
        end

endmodule

bind control_unit control_unit_checker u_checker (.*);

// ==== source/control_unit.sv ====
// Control unit decode stage top
// Capture, main and ALU decode, then issue, two cycles from strobe to result
module control_unit import mips_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        ctrl_valid,
    output logic        reg_write,
    output logic        reg_dst,
    output logic        alu_src_a,
    output logic        mem_write,
    output logic        mem_read,
    output logic        mem_to_reg,
    output logic        beq,
    output logic        bne,
    output logic        jump,
    output logic        se_ze,
    output logic        start_mult,
    output logic        mult_sign,
    output out_sel_t    out_select,
    output alu_op_t     alu_op,
    output logic [4:0]  dest_reg,
    output logic        illegal
);

    ctrl_word_t ctrl;          // Combinational decode
    ctrl_word_t ctrl_q;        // Issued word
    logic       op_illegal;
    logic       funct_illegal;
    alu_op_t    alu_op_d;

    instr_if u_instr_if ();

    instr_capture u_capture (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_o     (u_instr_if.capture)
    );

    main_decoder u_main_dec (
        .instr      (u_instr_if.decode),
        .ctrl       (ctrl),
        .op_illegal (op_illegal)
    );

    alu_decoder u_alu_dec (
        .instr         (u_instr_if.decode),
        .alu_mid       (ctrl.alu_mid),
        .alu_op        (alu_op_d),
        .funct_illegal (funct_illegal)
    );

    ctrl_issue u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr         (u_instr_if.decode),
        .ctrl          (ctrl),
        .op_illegal    (op_illegal),
        .alu_op        (alu_op_d),
        .funct_illegal (funct_illegal),
        .ctrl_valid    (ctrl_valid),
        .ctrl_q        (ctrl_q),
        .mem_read      (mem_read),
        .alu_op_q      (alu_op),
        .dest_reg      (dest_reg),
        .illegal       (illegal)
    );

    // Flatten the issued word onto the pins
    assign reg_write  = ctrl_q.reg_write;
    assign reg_dst    = ctrl_q.reg_dst;
    assign alu_src_a  = ctrl_q.alu_src_a;
    assign mem_write  = ctrl_q.mem_write;
    assign mem_to_reg = ctrl_q.mem_to_reg;
    assign beq        = ctrl_q.beq;
    assign bne        = ctrl_q.bne;
    assign jump       = ctrl_q.jump;
    assign se_ze      = ctrl_q.se_ze;
    assign start_mult = ctrl_q.start_mult;
    assign mult_sign  = ctrl_q.mult_sign;
    assign out_select = ctrl_q.out_select;

endmodule

// ==== source/ctrl_issue.sv ====
// Control issue register
// Latches the decoded control, ALU operation and destination index, pulses ctrl_valid
module ctrl_issue import mips_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    instr_if.decode    instr,
    input  ctrl_word_t ctrl,
    input  logic       op_illegal,
    input  alu_op_t    alu_op,
    input  logic       funct_illegal,
    output logic       ctrl_valid,
    output ctrl_word_t ctrl_q,
    output logic       mem_read,
    output alu_op_t    alu_op_q,
    output logic [4:0] dest_reg,
    output logic       illegal
);

    logic       illegal_d;
    ctrl_word_t ctrl_d;

    // Squash every side effect of an illegal instruction
    always_comb begin
        illegal_d = op_illegal | funct_illegal;
        ctrl_d    = ctrl;
        if (illegal_d) begin
            ctrl_d.reg_write  = 1'b0;
            ctrl_d.mem_write  = 1'b0;
            ctrl_d.start_mult = 1'b0;
            ctrl_d.beq        = 1'b0;
            ctrl_d.bne        = 1'b0;
            ctrl_d.jump       = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_valid <= 1'b0;
            ctrl_q     <= '0;
            mem_read   <= 1'b0;
            alu_op_q   <= ALU_ADD;  // Encoding zero
            dest_reg   <= 5'd0;
            illegal    <= 1'b0;
        end else begin
            ctrl_valid <= instr.valid;
            if (instr.valid) begin
                ctrl_q   <= ctrl_d;
                illegal  <= illegal_d;
                mem_read <= !illegal_d && !ctrl_d.mem_write;
                alu_op_q <= alu_op;
                dest_reg <= ctrl_d.reg_dst ? instr.rd : instr.rt;  // R-type writes rd
            end
        end
    end

endmodule

// ==== source/alu_decoder.sv ====
// ALU decoder
// Maps the coarse ALU class, and the funct for R-type, to a concrete ALU operation
module alu_decoder import mips_ctrl_pkg::*; (
    instr_if.decode  instr,
    input  alu_mid_t alu_mid,
    output alu_op_t  alu_op,
    output logic     funct_illegal
);

    always_comb begin
        alu_op        = ALU_NONE;
        funct_illegal = 1'b0;

        case (alu_mid)
            MID_ADD:  alu_op = ALU_ADD;
            MID_SUB:  alu_op = ALU_SUB;
            MID_AND:  alu_op = ALU_AND;
            MID_OR:   alu_op = ALU_OR;
            MID_XOR:  alu_op = ALU_XOR;
            MID_SLT:  alu_op = ALU_SLT;
            MID_SLTU: alu_op = ALU_SLTU;
            MID_FUNCT: begin
                case (funct_t'(instr.funct))
                    F_SLL:          alu_op = ALU_SLL;
                    F_SRL:          alu_op = ALU_SRL;
                    F_SRA:          alu_op = ALU_SRA;
                    F_ADD, F_ADDU:  alu_op = ALU_ADD;  // Overflow trap not modelled
                    F_SUB, F_SUBU:  alu_op = ALU_SUB;
                    F_AND:          alu_op = ALU_AND;
                    F_OR:           alu_op = ALU_OR;
                    F_XOR:          alu_op = ALU_XOR;
                    F_NOR:          alu_op = ALU_NOR;
                    F_SLT:          alu_op = ALU_SLT;
                    F_SLTU:         alu_op = ALU_SLTU;
                    default: begin
                        alu_op        = ALU_NONE;
                        funct_illegal = 1'b1;
                    end
                endcase
            end
            default: alu_op = ALU_NONE;
        endcase
    end

endmodule

// ==== source/main_decoder.sv ====
// Main decoder
// Turns opcode and funct into the control word, flagging unsupported opcodes
module main_decoder import mips_ctrl_pkg::*; (
    instr_if.decode    instr,
    output ctrl_word_t ctrl,
    output logic       op_illegal
);

    always_comb begin
        ctrl       = '0;  // Don't-cares resolve to zero
        op_illegal = 1'b0;

        case (opcode_t'(instr.op_code))
            OP_RTYPE: begin
                case (funct_t'(instr.funct))
                    F_NOOP: begin
                        ctrl = '0;
                    end
                    F_MFHI: begin
                        ctrl.reg_write  = 1'b1;
                        ctrl.reg_dst    = 1'b1;
                        ctrl.out_select = OUT_HI;
                    end
                    F_MFLO: begin
                        ctrl.reg_write  = 1'b1;
                        ctrl.reg_dst    = 1'b1;
                        ctrl.out_select = OUT_LO;
                    end
                    F_MULT: begin
                        ctrl.out_select = OUT_LO;
                        ctrl.start_mult = 1'b1;
                        ctrl.mult_sign  = 1'b1;  // Signed multiply
                    end
                    F_MULTU: begin
                        ctrl.reg_write  = 1'b1;
                        ctrl.reg_dst    = 1'b1;
                        ctrl.out_select = OUT_LO;
                        ctrl.start_mult = 1'b1;
                    end
                    default: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dst   = 1'b1;
                        ctrl.alu_mid   = MID_FUNCT;  // ALU decoder checks funct
                    end
                endcase
            end
            OP_J: begin
                ctrl.alu_mid = MID_SUB;
                ctrl.jump    = 1'b1;
            end
            OP_BEQ: begin
                ctrl.alu_mid = MID_SUB;  // Compare by subtraction
                ctrl.beq     = 1'b1;
            end
            OP_BNE: begin
                ctrl.alu_mid = MID_SUB;
                ctrl.bne     = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_a = 1'b1;
                case (opcode_t'(instr.op_code))
                    OP_SLTI:  ctrl.alu_mid = MID_SLT;
                    OP_SLTIU: ctrl.alu_mid = MID_SLTU;
                    OP_ANDI:  ctrl.alu_mid = MID_AND;
                    OP_ORI:   ctrl.alu_mid = MID_OR;
                    OP_XORI:  ctrl.alu_mid = MID_XOR;
                    default:  ctrl.alu_mid = MID_ADD;
                endcase
                // Logical immediates are zero extended
                ctrl.se_ze = !(opcode_t'(instr.op_code) inside {OP_ANDI, OP_ORI, OP_XORI});
            end
            OP_LUI: begin
                ctrl.reg_write  = 1'b1;
                ctrl.out_select = OUT_LUI;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src_a  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.se_ze      = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.se_ze     = 1'b1;
            end
            default: begin
                op_illegal = 1'b1;  // Word stays all zero
            end
        endcase
    end

endmodule

// ==== source/instr_capture.sv ====
// Instruction capture
// Registers the incoming word on its strobe and splits out the decode fields
module instr_capture (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           instr_valid,
    input  logic [31:0]    instr,
    instr_if.capture       instr_o
);

    logic        valid_q;
    logic [31:0] instr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;  // One cycle strobe follows the input
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q <= instr;
        end
    end

    // MIPS field layout
    assign instr_o.valid   = valid_q;
    assign instr_o.op_code = instr_q[31:26];
    assign instr_o.rt      = instr_q[20:16];
    assign instr_o.rd      = instr_q[15:11];
    assign instr_o.funct   = instr_q[5:0];

endmodule

// ==== source/instr_if.sv ====
// Captured instruction fields shared by the decode stage blocks
interface instr_if;

    logic       valid;    // Fields below hold only while high
    logic [5:0] op_code;  // Raw opcode bits
    logic [5:0] funct;
    logic [4:0] rt;
    logic [4:0] rd;

    modport capture (
        output valid,
        output op_code,
        output funct,
        output rt,
        output rd
    );

    modport decode (
        input valid,
        input op_code,
        input funct,
        input rt,
        input rd
    );

endinterface

// ==== source/mips_ctrl_pkg.sv ====
// Shared types for the MIPS-style decode stage
// Opcodes, functs, ALU classes and operations, result select and the control word
package mips_ctrl_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        F_NOOP  = 6'b000000,
        F_SRL   = 6'b000010,
        F_SRA   = 6'b000011,
        F_MFHI  = 6'b010000,
        F_MFLO  = 6'b010010,
        F_MULT  = 6'b011000,
        F_MULTU = 6'b011001,
        F_ADD   = 6'b100000,
        F_ADDU  = 6'b100001,
        F_SUB   = 6'b100010,
        F_SUBU  = 6'b100011,
        F_AND   = 6'b100100,
        F_OR    = 6'b100101,
        F_XOR   = 6'b100110,
        F_NOR   = 6'b100111,
        F_SLT   = 6'b101010,
        F_SLTU  = 6'b101011
    } funct_t;

    // SLL shares its encoding with NOOP, the main decoder claims it first
    localparam funct_t F_SLL = F_NOOP;

    typedef enum logic [2:0] {
        MID_ADD   = 3'b000,
        MID_SLTU  = 3'b001,
        MID_AND   = 3'b010,
        MID_OR    = 3'b011,
        MID_XOR   = 3'b100,
        MID_SLT   = 3'b101,
        MID_SUB   = 3'b110,
        MID_FUNCT = 3'b111     // Let the funct pick the operation
    } alu_mid_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_NONE = 4'd15
    } alu_op_t;

    typedef enum logic [1:0] {
        OUT_ALU = 2'b00,
        OUT_LUI = 2'b01,
        OUT_LO  = 2'b10,
        OUT_HI  = 2'b11
    } out_sel_t;

    typedef struct packed {
        logic     reg_write;   // 15
        logic     reg_dst;     // 14
        logic     alu_src_a;   // 13
        alu_mid_t alu_mid;     // 12:10
        logic     mem_write;   // 9
        logic     mem_to_reg;  // 8
        logic     beq;         // 7
        logic     bne;         // 6
        logic     jump;        // 5
        logic     se_ze;       // 4
        out_sel_t out_select;  // 3:2
        logic     start_mult;  // 1
        logic     mult_sign;   // 0
    } ctrl_word_t;

endpackage
